/* source/avl_tx_pkg.sv */
package avl_tx_pkg;

  // widths that carry a meaning
  typedef logic [31:0] avl_addr_t;   // byte address, 16-byte aligned on the bus
  typedef logic [5:0]  burst_cnt_t;  // 1 to 32 words
  typedef logic [9:0]  byte_cnt_t;   // segment or remainder, up to 512 bytes
  typedef logic [8:0]  dw_len_t;     // tlp length field in dwords
  typedef logic [3:0]  tag_t;

  localparam int WORD_BYTES          = 16;
  localparam int BOUNDARY_BYTES      = 4096;  // pcie address boundary
  // highest fill levels at which new work may go into the fifos
  localparam int CMD_FIFO_OK_LEVEL   = 8;
  localparam int WRDAT_FIFO_OK_LEVEL = 32;

  typedef enum logic [1:0]
  {
    REQ_WR,
    REQ_RD,
    REQ_MSI
  } req_kind_t;

  typedef enum logic [2:0]
  {
    IDLE,
    WR_BURST,
    WR_PIPE,
    WR_HEADER,
    RD_CALC,
    RD_HEADER,
    MSI_HEADER
  } tx_state_t;

  // one entry of the command fifo, always a 32-bit address format
  typedef struct packed
  {
    req_kind_t kind;
    logic      last_seg;  // final read segment
    tag_t      tag;
    dw_len_t   len;
    avl_addr_t addr;
  } tlp_req_t;

endpackage

/* source/msi_irq_capture.sv */
module msi_irq_capture
(
  input  logic AvlClk_i,
  input  logic Rstn_i,
  input  logic RxmIrq_i,
  input  logic irq_ena_i,
  input  logic msi_ena_i,
  input  logic msi_sent_i,
  output logic msi_pend_o
);

  logic irq_en;
  logic irq_en_q;
  logic irq_rise;

  assign irq_en   = RxmIrq_i & irq_ena_i;
  assign irq_rise = irq_en & ~irq_en_q;

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      irq_en_q   <= 1'b0;
      msi_pend_o <= 1'b0;
    end
    else
    begin
      irq_en_q <= irq_en;
      if (irq_rise & msi_ena_i)  // a new edge wins over the clear
        msi_pend_o <= 1'b1;
      else if (msi_sent_i)
        msi_pend_o <= 1'b0;
    end
  end

  // the fsm only emits an msi header for a request raised here
  a_sent_needs_pend: assert property (@(posedge AvlClk_i) disable iff (!Rstn_i)
    msi_sent_i |-> msi_pend_o);

endmodule

/* source/tx_req_fsm.sv */
module tx_req_fsm
(
  input  logic                   AvlClk_i,
  input  logic                   Rstn_i,
  input  logic                   TxChipSelect_i,
  input  logic                   TxRead_i,
  input  logic                   TxWrite_i,
  input  avl_tx_pkg::burst_cnt_t TxBurstCount_i,
  input  logic [3:0]             CmdFifoUsedW_i,
  input  logic [5:0]             WrDatFifoUsedW_i,
  input  logic                   MasterEnable_i,
  input  logic                   msi_pend_i,
  input  logic                   seg_full_i,
  input  logic                   rd_last_i,
  output logic                   TxWaitRequest_o,
  output logic                   WrDatFifoWrReq_o,
  output logic                   WrDatFifoEop_o,
  output logic                   wr_start_o,
  output logic                   wr_beat_o,
  output logic                   rd_start_o,
  output logic                   rd_adv_o,
  output logic                   hdr_wr_o,
  output logic                   hdr_rd_o,
  output logic                   hdr_msi_o,
  output logic                   msi_sent_o
);
  import avl_tx_pkg::*;

  tx_state_t  state_q;
  tx_state_t  state_d;
  burst_cnt_t beats_left;  // write words still to come
  logic       cmd_ok;
  logic       wrdat_ok;
  logic       idle;
  logic       go_msi;
  logic       go_wr;
  logic       go_rd;
  logic       beat;
  logic       seg_end;

  assign cmd_ok   = CmdFifoUsedW_i <= 4'(CMD_FIFO_OK_LEVEL);
  assign wrdat_ok = WrDatFifoUsedW_i <= 6'(WRDAT_FIFO_OK_LEVEL);

  // pending msi goes first, then new avalon commands
  assign idle   = state_q == IDLE;
  assign go_msi = idle & MasterEnable_i & msi_pend_i & cmd_ok;
  assign go_wr  = idle & MasterEnable_i & ~msi_pend_i & TxChipSelect_i & TxWrite_i
                  & cmd_ok & wrdat_ok;
  assign go_rd  = idle & MasterEnable_i & ~msi_pend_i & TxChipSelect_i & TxRead_i
                  & ~TxWrite_i & cmd_ok;

  assign beat    = (state_q == WR_BURST) & TxChipSelect_i & TxWrite_i & wrdat_ok;
  assign seg_end = beat & (seg_full_i | (beats_left == 6'd1));

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
      begin
        if (go_msi)
          state_d = MSI_HEADER;
        else if (go_wr)
          state_d = WR_BURST;
        else if (go_rd)
          state_d = RD_CALC;
      end
      WR_BURST:   if (seg_end) state_d = WR_PIPE;
      WR_PIPE:    if (cmd_ok) state_d = WR_HEADER;
      WR_HEADER:  state_d = (beats_left == '0) ? IDLE : WR_BURST;
      RD_CALC:    if (cmd_ok) state_d = RD_HEADER;  // size select settles here
      RD_HEADER:  state_d = rd_last_i ? IDLE : RD_CALC;
      MSI_HEADER: state_d = IDLE;
      default:    state_d = IDLE;
    endcase
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      state_q    <= IDLE;
      beats_left <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (go_wr)
        beats_left <= TxBurstCount_i;
      else if (beat)
        beats_left <= beats_left - 6'd1;
    end
  end

  // reads are taken in idle, write beats only while bursting
  assign TxWaitRequest_o  = ~(go_rd | ((state_q == WR_BURST) & wrdat_ok));
  assign WrDatFifoWrReq_o = beat;
  assign WrDatFifoEop_o   = seg_end;

  assign wr_start_o = go_wr;
  assign wr_beat_o  = beat;
  assign rd_start_o = go_rd;
  assign rd_adv_o   = state_q == RD_HEADER;
  assign hdr_wr_o   = state_q == WR_HEADER;
  assign hdr_rd_o   = state_q == RD_HEADER;
  assign hdr_msi_o  = state_q == MSI_HEADER;
  assign msi_sent_o = hdr_msi_o;

  a_wrdat_level: assert property (@(posedge AvlClk_i) disable iff (!Rstn_i)
    WrDatFifoWrReq_o |-> (WrDatFifoUsedW_i <= 6'(WRDAT_FIFO_OK_LEVEL)));

  a_hdr_onehot: assert property (@(posedge AvlClk_i) disable iff (!Rstn_i)
    $onehot0({hdr_wr_o, hdr_rd_o, hdr_msi_o}));

endmodule

/* source/wr_segmenter.sv */
module wr_segmenter
(
  input  logic                  AvlClk_i,
  input  logic                  Rstn_i,
  input  avl_tx_pkg::avl_addr_t TxAddress_i,
  input  logic                  wr_start_i,
  input  logic                  wr_beat_i,
  input  logic                  hdr_wr_i,
  input  logic [2:0]            mps_code_i,
  output logic                  seg_full_o,
  output avl_tx_pkg::avl_addr_t seg_addr_o,
  output avl_tx_pkg::dw_len_t   seg_len_o
);
  import avl_tx_pkg::*;

  avl_addr_t wr_addr_q;   // address of the next beat
  avl_addr_t seg_addr_q;  // start of the current segment
  byte_cnt_t payload_q;
  byte_cnt_t max_pl;

  // max payload size, anything above 256 is capped
  always_comb
  begin
    case (mps_code_i)
      3'b000:  max_pl = 10'd128;
      default: max_pl = 10'd256;
    endcase
  end

  always_ff @(posedge AvlClk_i)
  begin
    if (wr_start_i)
    begin
      wr_addr_q  <= {TxAddress_i[31:4], 4'h0};
      seg_addr_q <= {TxAddress_i[31:4], 4'h0};
    end
    else
    begin
      if (wr_beat_i)
        wr_addr_q <= wr_addr_q + avl_addr_t'(WORD_BYTES);
      if (hdr_wr_i)
        seg_addr_q <= wr_addr_q;  // next segment picks up where this one stopped
    end
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      payload_q <= '0;
    else if (wr_start_i | hdr_wr_i)
      payload_q <= '0;
    else if (wr_beat_i)
      payload_q <= payload_q + byte_cnt_t'(WORD_BYTES);
  end

  // next beat is the last word before 4 KB or fills the payload
  assign seg_full_o = (wr_addr_q[11:4] == 8'hFF)
                      | (payload_q == (max_pl - byte_cnt_t'(WORD_BYTES)));

  assign seg_addr_o = seg_addr_q;
  assign seg_len_o  = {1'b0, payload_q[9:2]};

endmodule

/* source/rd_splitter.sv */
module rd_splitter
(
  input  logic                   AvlClk_i,
  input  logic                   Rstn_i,
  input  avl_tx_pkg::avl_addr_t  TxAddress_i,
  input  avl_tx_pkg::burst_cnt_t TxBurstCount_i,
  input  logic                   rd_start_i,
  input  logic                   rd_adv_i,
  input  logic [2:0]             mrrs_code_i,
  output avl_tx_pkg::avl_addr_t  rd_addr_o,
  output avl_tx_pkg::dw_len_t    rd_len_o,
  output logic                   rd_last_o
);
  import avl_tx_pkg::*;

  avl_addr_t   rd_addr_q;
  byte_cnt_t   remain_q;     // bytes not yet requested
  byte_cnt_t   max_rd;
  logic [12:0] to_bnd;       // bytes left to the next 4 KB boundary
  byte_cnt_t   to_bnd_q;
  logic        sel_remain;
  logic        sel_bnd;
  logic        sel_remain_q;
  logic        sel_bnd_q;
  byte_cnt_t   rd_size;

  always_comb
  begin
    case (mrrs_code_i)
      3'b000:  max_rd = 10'd128;
      3'b001:  max_rd = 10'd256;
      default: max_rd = 10'd512;
    endcase
  end

  assign to_bnd     = 13'(BOUNDARY_BYTES) - {1'b0, rd_addr_q[11:0]};
  assign sel_remain = ({3'b000, remain_q} <= to_bnd) & (remain_q <= max_rd);
  assign sel_bnd    = (to_bnd <= {3'b000, max_rd}) & ({3'b000, remain_q} > to_bnd);

  // select is pipelined, the fsm gives it one cycle in RD_CALC
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      sel_remain_q <= 1'b0;
      sel_bnd_q    <= 1'b0;
    end
    else
    begin
      sel_remain_q <= sel_remain;
      sel_bnd_q    <= sel_bnd;
    end
  end

  // only used when selected, then it is at most 512
  always_ff @(posedge AvlClk_i)
    to_bnd_q <= to_bnd[9:0];

  assign rd_size = sel_remain_q ? remain_q : (sel_bnd_q ? to_bnd_q : max_rd);

  always_ff @(posedge AvlClk_i)
  begin
    if (rd_start_i)
      rd_addr_q <= {TxAddress_i[31:4], 4'h0};
    else if (rd_adv_i)
      rd_addr_q <= rd_addr_q + {22'd0, rd_size};
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      remain_q <= '0;
    else if (rd_start_i)
      remain_q <= {TxBurstCount_i, 4'h0};  // words to bytes
    else if (rd_adv_i)
      remain_q <= remain_q - rd_size;
  end

  assign rd_addr_o = rd_addr_q;
  assign rd_len_o  = {1'b0, rd_size[9:2]};
  assign rd_last_o = sel_remain_q;  // the rest fits in this segment

endmodule

/* source/tlp_hdr_builder.sv */
module tlp_hdr_builder
(
  input  logic                  AvlClk_i,
  input  logic                  Rstn_i,
  input  logic                  hdr_wr_i,
  input  logic                  hdr_rd_i,
  input  logic                  hdr_msi_i,
  input  avl_tx_pkg::avl_addr_t seg_addr_i,
  input  avl_tx_pkg::dw_len_t   seg_len_i,
  input  avl_tx_pkg::avl_addr_t rd_addr_i,
  input  avl_tx_pkg::dw_len_t   rd_len_i,
  input  logic                  rd_last_i,
  input  avl_tx_pkg::avl_addr_t msi_addr_i,
  output logic                  TxReqWr_o,
  output avl_tx_pkg::tlp_req_t  TxReqHeader_o
);
  import avl_tx_pkg::*;

  tag_t     tag_q;
  tlp_req_t hdr;

  always_comb
  begin
    hdr = '0;  // write with tag 0 unless told otherwise
    if (hdr_rd_i)
    begin
      hdr.kind     = REQ_RD;
      hdr.last_seg = rd_last_i;
      hdr.tag      = tag_q;
      hdr.len      = rd_len_i;
      hdr.addr     = rd_addr_i;
    end
    else if (hdr_msi_i)
    begin
      hdr.kind = REQ_MSI;
      hdr.len  = 9'd1;         // single dword
      hdr.addr = msi_addr_i;
    end
    else
    begin
      hdr.kind = REQ_WR;
      hdr.len  = seg_len_i;
      hdr.addr = seg_addr_i;
    end
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      tag_q <= '0;
    else if (hdr_rd_i)
      tag_q <= tag_q + 4'd1;  // rolls over after 15
  end

  assign TxReqWr_o     = hdr_wr_i | hdr_rd_i | hdr_msi_i;
  assign TxReqHeader_o = hdr;

endmodule

/* source/avl_tx_req.sv */
module avl_tx_req
(
  input  logic                   AvlClk_i,
  input  logic                   Rstn_i,
  input  logic                   TxChipSelect_i,
  input  logic                   TxRead_i,
  input  logic                   TxWrite_i,
  input  avl_tx_pkg::burst_cnt_t TxBurstCount_i,
  input  avl_tx_pkg::avl_addr_t  TxAddress_i,
  output logic                   TxWaitRequest_o,
  output logic                   TxReqWr_o,
  output avl_tx_pkg::tlp_req_t   TxReqHeader_o,
  input  logic [3:0]             CmdFifoUsedW_i,
  output logic                   WrDatFifoWrReq_o,
  output logic                   WrDatFifoEop_o,
  input  logic [5:0]             WrDatFifoUsedW_i,
  input  logic [31:0]            DevCsr_i,
  input  logic                   MasterEnable_i,
  input  logic [15:0]            MsiCsr_i,
  input  logic [63:0]            MsiAddr_i,
  input  logic [15:0]            PCIeIrqEna_i,
  input  logic                   RxmIrq_i
);
  import avl_tx_pkg::*;

  logic      msi_pend;
  logic      msi_sent;
  logic      wr_start;
  logic      wr_beat;
  logic      rd_start;
  logic      rd_adv;
  logic      hdr_wr;
  logic      hdr_rd;
  logic      hdr_msi;
  logic      seg_full;
  logic      rd_last;
  avl_addr_t seg_addr;
  dw_len_t   seg_len;
  avl_addr_t rd_addr;
  dw_len_t   rd_len;

  msi_irq_capture u_msi (
    .AvlClk_i   (AvlClk_i),
    .Rstn_i     (Rstn_i),
    .RxmIrq_i   (RxmIrq_i),
    .irq_ena_i  (PCIeIrqEna_i[0]),
    .msi_ena_i  (MsiCsr_i[0]),
    .msi_sent_i (msi_sent),
    .msi_pend_o (msi_pend)
  );

  tx_req_fsm u_fsm (
    .AvlClk_i         (AvlClk_i),
    .Rstn_i           (Rstn_i),
    .TxChipSelect_i   (TxChipSelect_i),
    .TxRead_i         (TxRead_i),
    .TxWrite_i        (TxWrite_i),
    .TxBurstCount_i   (TxBurstCount_i),
    .CmdFifoUsedW_i   (CmdFifoUsedW_i),
    .WrDatFifoUsedW_i (WrDatFifoUsedW_i),
    .MasterEnable_i   (MasterEnable_i),
    .msi_pend_i       (msi_pend),
    .seg_full_i       (seg_full),
    .rd_last_i        (rd_last),
    .TxWaitRequest_o  (TxWaitRequest_o),
    .WrDatFifoWrReq_o (WrDatFifoWrReq_o),
    .WrDatFifoEop_o   (WrDatFifoEop_o),
    .wr_start_o       (wr_start),
    .wr_beat_o        (wr_beat),
    .rd_start_o       (rd_start),
    .rd_adv_o         (rd_adv),
    .hdr_wr_o         (hdr_wr),
    .hdr_rd_o         (hdr_rd),
    .hdr_msi_o        (hdr_msi),
    .msi_sent_o       (msi_sent)
  );

  wr_segmenter u_wr_seg (
    .AvlClk_i    (AvlClk_i),
    .Rstn_i      (Rstn_i),
    .TxAddress_i (TxAddress_i),
    .wr_start_i  (wr_start),
    .wr_beat_i   (wr_beat),
    .hdr_wr_i    (hdr_wr),
    .mps_code_i  (DevCsr_i[7:5]),
    .seg_full_o  (seg_full),
    .seg_addr_o  (seg_addr),
    .seg_len_o   (seg_len)
  );

  rd_splitter u_rd_split (
    .AvlClk_i       (AvlClk_i),
    .Rstn_i         (Rstn_i),
    .TxAddress_i    (TxAddress_i),
    .TxBurstCount_i (TxBurstCount_i),
    .rd_start_i     (rd_start),
    .rd_adv_i       (rd_adv),
    .mrrs_code_i    (DevCsr_i[14:12]),
    .rd_addr_o      (rd_addr),
    .rd_len_o       (rd_len),
    .rd_last_o      (rd_last)
  );

  tlp_hdr_builder u_hdr (
    .AvlClk_i      (AvlClk_i),
    .Rstn_i        (Rstn_i),
    .hdr_wr_i      (hdr_wr),
    .hdr_rd_i      (hdr_rd),
    .hdr_msi_i     (hdr_msi),
    .seg_addr_i    (seg_addr),
    .seg_len_i     (seg_len),
    .rd_addr_i     (rd_addr),
    .rd_len_i      (rd_len),
    .rd_last_i     (rd_last),
    .msi_addr_i    (MsiAddr_i[31:0]),  // 32-bit headers only
    .TxReqWr_o     (TxReqWr_o),
    .TxReqHeader_o (TxReqHeader_o)
  );

endmodule

/* sim/tx_req_checker.sv */
module tx_req_checker
(
  input  logic                   AvlClk_i,
  input  logic                   Rstn_i,
  input  logic                   TxChipSelect_i,
  input  logic                   TxRead_i,
  input  logic                   TxWrite_i,
  input  avl_tx_pkg::burst_cnt_t TxBurstCount_i,
  input  avl_tx_pkg::avl_addr_t  TxAddress_i,
  input  logic                   TxWaitRequest_o,
  input  logic                   TxReqWr_o,
  input  avl_tx_pkg::tlp_req_t   TxReqHeader_o,
  input  logic [3:0]             CmdFifoUsedW_i,
  input  logic                   WrDatFifoWrReq_o,
  input  logic                   WrDatFifoEop_o,
  input  logic [5:0]             WrDatFifoUsedW_i,
  input  logic [31:0]            DevCsr_i,
  input  logic [15:0]            MsiCsr_i,
  input  logic [63:0]            MsiAddr_i,
  input  logic [15:0]            PCIeIrqEna_i,
  input  logic                   RxmIrq_i,
  input  logic [127:0]           test_name_i,
  output int                     pending_o,
  output int                     value_errs_o,
  output int                     other_errs_o
);
  import avl_tx_pkg::*;

  tlp_req_t exp_q[$];        // headers still to come, in order
  int       seg_beats_q[$];  // beats per write segment still to come
  int       wr_left;
  int       seg_beat;
  tag_t     next_tag;
  logic     irq_q;
  logic     irq_now;
  logic     cmd_ok_q;
  logic     rst_q;
  logic     wr_xfer;
  logic     rd_xfer;
  logic     eop_exp;
  tlp_req_t exp_h;

  task automatic report_value(input string what, input logic [47:0] exp_v,
                              input logic [47:0] act_v);
    begin
      $display("[FAIL] %0s %0s expected %h actual %h", test_name_i, what, exp_v, act_v);
      value_errs_o = value_errs_o + 1;
    end
  endtask

  task automatic report_other(input string msg);
    begin
      $display("ERROR in %0s at %0t: %0s", test_name_i, $time, msg);
      other_errs_o = other_errs_o + 1;
    end
  endtask

  // segment ends at the payload limit, the 4 KB boundary or the last beat
  task automatic predict_write(input avl_addr_t start, input int beats);
    avl_addr_t a;
    tlp_req_t  h;
    int        left;
    int        n;
    int        mps;
    logic      seg_open;
    begin
      mps  = (DevCsr_i[7:5] == 3'd0) ? 128 : 256;
      a    = start;
      left = beats;
      while (left > 0)
      begin
        h        = '0;
        h.kind   = REQ_WR;
        h.addr   = a;
        n        = 0;
        seg_open = 1'b1;
        while (seg_open)
        begin
          n        = n + 1;
          a        = a + 32'd16;
          left     = left - 1;
          seg_open = (left > 0) && (a[11:0] != 12'd0) && (n * 16 < mps);
        end
        h.len = dw_len_t'(n * 4);
        exp_q.push_back(h);
        seg_beats_q.push_back(n);
      end
    end
  endtask

  // size is the least of remainder, max read size and bytes to the boundary
  task automatic predict_read(input avl_addr_t start, input int words);
    avl_addr_t a;
    tlp_req_t  h;
    int        remain;
    int        sz;
    int        max_rd;
    begin
      case (DevCsr_i[14:12])
        3'd0:    max_rd = 128;
        3'd1:    max_rd = 256;
        default: max_rd = 512;
      endcase
      a      = start;
      remain = words * 16;
      while (remain > 0)
      begin
        sz = remain;
        if (max_rd < sz)
          sz = max_rd;
        if (4096 - int'(a[11:0]) < sz)
          sz = 4096 - int'(a[11:0]);
        remain     = remain - sz;
        h          = '0;
        h.kind     = REQ_RD;
        h.last_seg = (remain == 0);
        h.tag      = next_tag;
        h.len      = dw_len_t'(sz / 4);
        h.addr     = a;
        exp_q.push_back(h);
        next_tag = next_tag + 4'd1;  // wraps after 15
        a        = a + avl_addr_t'(sz);
      end
    end
  endtask

  always @(negedge AvlClk_i)
  begin
    irq_now = RxmIrq_i & PCIeIrqEna_i[0];
    if (!Rstn_i || rst_q)
    begin
      if (!TxWaitRequest_o || TxReqWr_o || WrDatFifoWrReq_o || WrDatFifoEop_o)
        report_other("outputs are not at their reset values");
    end
    if (!Rstn_i)
    begin
      exp_q.delete();
      seg_beats_q.delete();
      wr_left  = 0;
      seg_beat = 0;
      next_tag = '0;
      irq_now  = 1'b0;
    end
    else
    begin
      wr_xfer = TxChipSelect_i & TxWrite_i & ~TxWaitRequest_o;
      rd_xfer = TxRead_i & ~TxWaitRequest_o;
      if (WrDatFifoWrReq_o != wr_xfer)
        report_other("write data strobe does not match the Avalon write handshake");
      if (WrDatFifoWrReq_o && (WrDatFifoUsedW_i > 6'd32))
        report_other("write data strobe while the write-data FIFO is above its threshold");
      if (TxReqWr_o && !cmd_ok_q)
        report_other("header written without command FIFO room in the cycle before");
      if (wr_xfer)
      begin
        if (wr_left == 0)  // first beat of a new burst
        begin
          predict_write(TxAddress_i, int'(TxBurstCount_i));
          wr_left  = int'(TxBurstCount_i);
          seg_beat = 0;
        end
        wr_left  = wr_left - 1;
        seg_beat = seg_beat + 1;
        eop_exp  = (seg_beats_q.size() > 0) && (seg_beat == seg_beats_q[0]);
        if (WrDatFifoEop_o != eop_exp)
          report_value("eop", {47'd0, eop_exp}, {47'd0, WrDatFifoEop_o});
        if (eop_exp)
        begin
          void'(seg_beats_q.pop_front());
          seg_beat = 0;
        end
      end
      else if (WrDatFifoEop_o)
        report_other("EOP strobe without a data beat");
      if (rd_xfer)
        predict_read(TxAddress_i, int'(TxBurstCount_i));
      if (irq_now && !irq_q && MsiCsr_i[0])
      begin
        exp_h      = '0;
        exp_h.kind = REQ_MSI;
        exp_h.len  = 9'd1;
        exp_h.addr = MsiAddr_i[31:0];
        exp_q.push_back(exp_h);
      end
      if (TxReqWr_o)
      begin
        if (exp_q.size() == 0)
          report_other("header written with no request behind it");
        else
        begin
          exp_h = exp_q.pop_front();
          if (TxReqHeader_o !== exp_h)
            report_value("header", exp_h, TxReqHeader_o);
        end
      end
    end
    irq_q     = irq_now;
    cmd_ok_q  = CmdFifoUsedW_i <= 4'd8;
    rst_q     = !Rstn_i;
    pending_o = exp_q.size();
  end

endmodule

/* sim/tb_avl_tx_req.sv */
module tb_avl_tx_req;
  import avl_tx_pkg::*;

  typedef enum logic [1:0] {OP_WR, OP_RD, OP_IRQ} op_t;

  typedef struct packed
  {
    logic [127:0] name;
    op_t          op;
    avl_addr_t    addr;
    burst_cnt_t   burst;
    logic [2:0]   mps;     // DevCsr bits 7:5
    logic [2:0]   mrrs;    // DevCsr bits 14:12
    logic         msi_en;
  } test_row_t;

  localparam int NUM_ROWS   = 15;
  localparam int RST_CYCLES = 16;
  localparam int ROW_CYCLES = 400;

  logic         AvlClk_i;
  logic         Rstn_i;
  logic         TxChipSelect_i;
  logic         TxRead_i;
  logic         TxWrite_i;
  burst_cnt_t   TxBurstCount_i;
  avl_addr_t    TxAddress_i;
  logic         TxWaitRequest_o;
  logic         TxReqWr_o;
  tlp_req_t     TxReqHeader_o;
  logic [3:0]   CmdFifoUsedW_i = '0;
  logic         WrDatFifoWrReq_o;
  logic         WrDatFifoEop_o;
  logic [5:0]   WrDatFifoUsedW_i = '0;
  logic [31:0]  DevCsr_i;
  logic         MasterEnable_i;
  logic [15:0]  MsiCsr_i;
  logic [63:0]  MsiAddr_i;
  logic [15:0]  PCIeIrqEna_i;
  logic         RxmIrq_i;
  logic [127:0] cur_name;
  int           pending;
  int           value_errs;
  int           other_errs;
  logic [31:0]  rnd = 32'hd70094c9;
  test_row_t    rows [NUM_ROWS];

  avl_tx_req uut (.*);

  tx_req_checker u_chk (
    .test_name_i  (cur_name),
    .pending_o    (pending),
    .value_errs_o (value_errs),
    .other_errs_o (other_errs),
    .*
  );

  always #20 AvlClk_i = ~AvlClk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // fill levels mostly below the thresholds so work keeps moving
  always @(posedge AvlClk_i)
  begin
    if (Rstn_i)
    begin
      rnd = lcg_next(rnd);
      CmdFifoUsedW_i   <= 4'(rnd[31:16] % 16'd12);
      WrDatFifoUsedW_i <= 6'(rnd[15:0] % 16'd44);
    end
  end

  task automatic load_table;
    begin
      rows[0]  = '{"wr_small",      OP_WR,  32'h0000_1000, 6'd4,  3'd0, 3'd0, 1'b0};
      rows[1]  = '{"wr_mps128",     OP_WR,  32'h0000_2000, 6'd20, 3'd0, 3'd0, 1'b0};
      rows[2]  = '{"wr_mps256",     OP_WR,  32'h0000_3040, 6'd32, 3'd1, 3'd0, 1'b0};
      rows[3]  = '{"wr_4k_cross",   OP_WR,  32'h0000_4FC0, 6'd10, 3'd1, 3'd0, 1'b0};
      rows[4]  = '{"wr_4k_mps",     OP_WR,  32'h0000_5F80, 6'd16, 3'd0, 3'd0, 1'b0};
      rows[5]  = '{"rd_small",      OP_RD,  32'h0000_6000, 6'd4,  3'd0, 3'd0, 1'b0};
      rows[6]  = '{"rd_mrrs128",    OP_RD,  32'h0000_7000, 6'd20, 3'd0, 3'd0, 1'b0};
      rows[7]  = '{"rd_mrrs512",    OP_RD,  32'h0000_8010, 6'd32, 3'd0, 3'd2, 1'b0};
      rows[8]  = '{"rd_4k",         OP_RD,  32'h0000_9F40, 6'd24, 3'd0, 3'd2, 1'b0};
      rows[9]  = '{"rd_4k_mrrs256", OP_RD,  32'h0000_AFF0, 6'd32, 3'd0, 3'd1, 1'b0};
      rows[10] = '{"irq_msi_on",    OP_IRQ, 32'h0000_0000, 6'd0,  3'd0, 3'd0, 1'b1};
      rows[11] = '{"irq_msi_off",   OP_IRQ, 32'h0000_0000, 6'd0,  3'd0, 3'd0, 1'b0};
      rows[12] = '{"rd_tag_wrap_a", OP_RD,  32'h0000_B000, 6'd32, 3'd0, 3'd0, 1'b0};
      rows[13] = '{"rd_tag_wrap_b", OP_RD,  32'h0000_C000, 6'd32, 3'd0, 3'd0, 1'b0};
      rows[14] = '{"wr_bnd_edge",   OP_WR,  32'h0000_EFF0, 6'd3,  3'd1, 3'd0, 1'b0};
    end
  endtask

  // hold the burst until every beat went through
  task automatic drive_write(input avl_addr_t addr, input burst_cnt_t burst);
    int sent;
    begin
      sent = 0;
      @(posedge AvlClk_i);
      TxChipSelect_i <= 1'b1;
      TxWrite_i      <= 1'b1;
      TxAddress_i    <= addr;
      TxBurstCount_i <= burst;
      while (sent < int'(burst))
      begin
        @(negedge AvlClk_i);
        if (!TxWaitRequest_o)
          sent = sent + 1;
        @(posedge AvlClk_i);
      end
      TxChipSelect_i <= 1'b0;
      TxWrite_i      <= 1'b0;
    end
  endtask

  task automatic drive_read(input avl_addr_t addr, input burst_cnt_t burst);
    logic taken;
    begin
      taken = 1'b0;
      @(posedge AvlClk_i);
      TxChipSelect_i <= 1'b1;
      TxRead_i       <= 1'b1;
      TxAddress_i    <= addr;
      TxBurstCount_i <= burst;
      while (!taken)
      begin
        @(negedge AvlClk_i);
        taken = !TxWaitRequest_o;
        @(posedge AvlClk_i);
      end
      TxChipSelect_i <= 1'b0;
      TxRead_i       <= 1'b0;
    end
  endtask

  task automatic run_row(input test_row_t row);
    begin
      @(posedge AvlClk_i);
      cur_name <= row.name;
      DevCsr_i <= {17'd0, row.mrrs, 4'd0, row.mps, 5'd0};
      MsiCsr_i <= {15'd0, row.msi_en};
      case (row.op)
        OP_WR:   drive_write(row.addr, row.burst);
        OP_RD:   drive_read(row.addr, row.burst);
        default:
        begin
          @(posedge AvlClk_i);
          RxmIrq_i <= 1'b1;
          repeat (2) @(posedge AvlClk_i);  // edge seen by the checker
        end
      endcase
      if ((row.op == OP_IRQ) && !row.msi_en)
        repeat (20) @(posedge AvlClk_i);  // window for a header that must not come
      while (pending != 0)
        @(posedge AvlClk_i);
      RxmIrq_i <= 1'b0;
    end
  endtask

  task automatic print_counts(input int timeouts);
    begin
      $display("checks finished: %0d value errors, %0d other errors, %0d timeouts",
               value_errs, other_errs, timeouts);
    end
  endtask

  initial
  begin
    AvlClk_i       = 1'b0;
    Rstn_i         = 1'b0;
    TxChipSelect_i = 1'b0;
    TxRead_i       = 1'b0;
    TxWrite_i      = 1'b0;
    TxBurstCount_i = '0;
    TxAddress_i    = '0;
    DevCsr_i       = '0;
    MasterEnable_i = 1'b1;
    MsiCsr_i       = '0;
    MsiAddr_i      = 64'h1234_5678_FEE0_0040;  // upper half is ignored
    PCIeIrqEna_i   = 16'h0001;
    RxmIrq_i       = 1'b0;
    cur_name       = "reset";
    load_table();
    repeat (RST_CYCLES) @(posedge AvlClk_i);
    Rstn_i <= 1'b1;
    for (int i = 0; i < NUM_ROWS; i++)
      run_row(rows[i]);
    repeat (10) @(posedge AvlClk_i);
    print_counts(0);
    if ((value_errs + other_errs) == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

  // watchdog
  initial
  begin
    repeat (RST_CYCLES + NUM_ROWS * ROW_CYCLES) @(posedge AvlClk_i);
    $display("timeout in %0s, the tests did not finish within %0d cycles", cur_name,
             RST_CYCLES + NUM_ROWS * ROW_CYCLES);
    print_counts(1);
    $display("Regression failed");
    $finish;
  end

endmodule

/* avl_tx_req.f */
source/avl_tx_pkg.sv
source/msi_irq_capture.sv
source/tx_req_fsm.sv
source/wr_segmenter.sv
source/rd_splitter.sv
source/tlp_hdr_builder.sv
source/avl_tx_req.sv
sim/tx_req_checker.sv
sim/tb_avl_tx_req.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the avl_tx_req testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_avl_tx_req \
  -Mdir obj_dir -f avl_tx_req.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_avl_tx_req > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Regression failed" "$LOG"; then
  exit 1
fi
exit 0
